// File: edge_defines.svh
`ifndef EDGE_DEFINES_SVH
`define EDGE_DEFINES_SVH

// Edge field and cache line geometry
`define EDGE_BITS 32
`define LINE_BYTES 64
`define LINE_EDGES 16
`define LINE_BITS 512

// Byte address width on the memory side
`define ADDR_BITS 64

// Default depth of the edge queue, holds two full lines
`define EDGE_QUEUE_DEPTH 32

`endif

// File: graph_pkg.sv
`include "edge_defines.svh"

package graph_pkg;

	// One vertex job, as handed in by the vertex scheduler
	typedef struct packed {
		logic                  valid;
		logic [`EDGE_BITS-1:0] id;
		logic [`EDGE_BITS-1:0] edge_idx;
		logic [`EDGE_BITS-1:0] degree;
	} vertex_job_t;

	// One unpacked edge
	typedef struct packed {
		logic                  valid;
		logic [`EDGE_BITS-1:0] id;
		logic [`EDGE_BITS-1:0] src;
		logic [`EDGE_BITS-1:0] dest;
		logic [`EDGE_BITS-1:0] weight;
	} edge_t;

	// Byte base addresses of the three inverse edge arrays
	typedef struct packed {
		logic [`ADDR_BITS-1:0] src_base;
		logic [`ADDR_BITS-1:0] dest_base;
		logic [`ADDR_BITS-1:0] weight_base;
	} array_base_t;

endpackage

// File: mem_pkg.sv
`include "edge_defines.svh"

package mem_pkg;

	// Which edge array a line belongs to
	typedef enum logic [1:0] {
		ARR_SRC,
		ARR_DEST,
		ARR_WEIGHT
	} array_tag_e;

	// Shared read, no-allocate read, partial no-allocate read
	typedef enum logic [1:0] {
		READ_CL_S,
		READ_CL_NA,
		READ_PNA
	} read_opcode_e;

	// Line read command, one per array and line
	typedef struct packed {
		logic                              valid;
		read_opcode_e                      opcode;
		logic [`ADDR_BITS-1:0]             address;
		array_tag_e                        tag;
		logic [$clog2(`LINE_EDGES):0]      edge_count;
		logic [$clog2(`LINE_EDGES)-1:0]    first_slot;
	} read_cmd_t;

	// Returned line, echoes tag, count and first slot of its command
	typedef struct packed {
		logic                              valid;
		array_tag_e                        tag;
		logic [$clog2(`LINE_EDGES):0]      edge_count;
		logic [$clog2(`LINE_EDGES)-1:0]    first_slot;
		logic [`LINE_BITS-1:0]             line;
	} read_data_t;

endpackage

// File: sync_fifo.sv
module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         push,
	input  logic [WIDTH-1:0]             data_in,
	input  logic                         pop,
	output logic [WIDTH-1:0]             data_out,
	output logic                         empty,
	output logic [$clog2(DEPTH+1)-1:0]   count
);
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic                do_push;
	logic                do_pop;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign do_pop = pop && !empty;
	// Full queue still takes a push when the head leaves
	assign do_push = push && ((int'(count) < DEPTH) || do_pop);

	// Show-ahead head
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: edge_read_request.sv
`include "edge_defines.svh"

module edge_read_request (
	input  logic                   clock,
	input  logic                   rstn,
	input  graph_pkg::array_base_t base,
	input  logic                   cache_mode,
	input  graph_pkg::vertex_job_t vertex_in,
	output logic                   vertex_ready,
	input  logic                   queue_room,
	input  logic                   line_done,
	output mem_pkg::read_cmd_t     read_cmd,
	output mem_pkg::read_cmd_t     line_cmd,
	output logic                   vertex_start
);
	import mem_pkg::*;

	localparam int ADDR_W = `ADDR_BITS;
	localparam int OFF_BITS = $clog2(`LINE_BYTES);
	localparam int BYTE_SHIFT = $clog2(`EDGE_BITS / 8);
	localparam int SLOT_BITS = $clog2(`LINE_EDGES);
	localparam int CNT_BITS = SLOT_BITS + 1;

	typedef enum logic [2:0] {
		IDLE,
		WAIT_ROOM,
		CALC,
		SEND_SRC,
		SEND_DEST,
		SEND_WEIGHT,
		WAIT_LINE
	} state_e;

	state_e                state;
	state_e                state_next;
	logic                  accept;
	logic [`EDGE_BITS-1:0] remaining;
	logic [ADDR_W-1:0]     offset;
	logic [OFF_BITS-1:0]   remainder;
	logic [ADDR_W-1:0]     aligned;
	logic [CNT_BITS-1:0]   slots_left;
	logic [CNT_BITS-1:0]   count;
	logic                  last_line;
	read_cmd_t             cmd_q;

	assign vertex_ready = (state == IDLE);
	assign accept = vertex_in.valid && vertex_ready;
	assign vertex_start = accept;

	////////////////////
	// Line split
	////////////////////

	assign remainder = offset[OFF_BITS-1:0];
	assign aligned = {offset[ADDR_W-1:OFF_BITS], {OFF_BITS{1'b0}}};
	assign slots_left = CNT_BITS'(`LINE_EDGES) - CNT_BITS'(remainder[OFF_BITS-1:BYTE_SHIFT]);
	assign last_line = (remaining <= slots_left);
	assign count = last_line ? remaining[CNT_BITS-1:0] : slots_left;

	////////////////////
	// Request FSM
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				// Zero degree stays here, nothing to fetch
				if (accept && (vertex_in.degree != '0)) begin
					state_next = WAIT_ROOM;
				end
			end
			WAIT_ROOM: begin
				if (queue_room) begin
					state_next = CALC;
				end
			end
			CALC:        state_next = SEND_SRC;
			SEND_SRC:    state_next = SEND_DEST;
			SEND_DEST:   state_next = SEND_WEIGHT;
			SEND_WEIGHT: state_next = WAIT_LINE;
			WAIT_LINE: begin
				if (line_done) begin
					state_next = (remaining == '0) ? IDLE : WAIT_ROOM;
				end
			end
			default:     state_next = IDLE;
		endcase
	end

	// Vertex latch, offset walk and line command
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining <= '0;
			offset <= '0;
			cmd_q <= '0;
		end else begin
			if (accept) begin
				remaining <= vertex_in.degree;
				offset <= ADDR_W'({vertex_in.edge_idx, {BYTE_SHIFT{1'b0}}});
			end
			if (state == CALC) begin
				cmd_q.valid <= 1'b1;
				cmd_q.address <= aligned;
				cmd_q.tag <= ARR_SRC;
				cmd_q.edge_count <= count;
				cmd_q.first_slot <= remainder[OFF_BITS-1:BYTE_SHIFT];
				if (cache_mode) begin
					cmd_q.opcode <= READ_CL_S;
				end else begin
					// Partial read only for the line that ends the vertex
					cmd_q.opcode <= last_line ? READ_PNA : READ_CL_NA;
				end
				offset <= aligned + `LINE_BYTES;
				remaining <= remaining - count;
			end
			if ((state == WAIT_LINE) && line_done) begin
				cmd_q.valid <= 1'b0;
			end
		end
	end

	// One command per array, base plus aligned line offset
	always_comb begin
		read_cmd = cmd_q;
		read_cmd.valid = 1'b0;
		case (state)
			SEND_SRC: begin
				read_cmd.valid = 1'b1;
				read_cmd.tag = ARR_SRC;
				read_cmd.address = base.src_base + cmd_q.address;
			end
			SEND_DEST: begin
				read_cmd.valid = 1'b1;
				read_cmd.tag = ARR_DEST;
				read_cmd.address = base.dest_base + cmd_q.address;
			end
			SEND_WEIGHT: begin
				read_cmd.valid = 1'b1;
				read_cmd.tag = ARR_WEIGHT;
				read_cmd.address = base.weight_base + cmd_q.address;
			end
			default: begin
			end
		endcase
	end

	assign line_cmd = cmd_q;

endmodule

// File: edge_line_unpack.sv
`include "edge_defines.svh"

module edge_line_unpack (
	input  logic                clock,
	input  logic                rstn,
	input  mem_pkg::read_data_t read_data,
	input  mem_pkg::read_cmd_t  line_cmd,
	output graph_pkg::edge_t    raw_edge,
	output logic                line_done
);
	import mem_pkg::*;

	localparam int SLOT_BITS = $clog2(`LINE_EDGES);
	localparam int CNT_BITS = SLOT_BITS + 1;

	logic [`LINE_BITS-1:0] lines [3];
	logic [`EDGE_BITS-1:0] words [3];
	logic [2:0]            ready;
	logic                  capture;
	logic                  start;
	logic                  busy;
	logic [SLOT_BITS-1:0]  slot;
	logic [CNT_BITS-1:0]   left;
	logic                  edge_valid;

	assign capture = read_data.valid && line_cmd.valid;
	assign start = (&ready) && !busy;

	////////////////////
	// Line capture
	////////////////////

	// One full line per array, indexed by tag
	always_ff @(posedge clock) begin
		if (capture) begin
			lines[read_data.tag] <= read_data.line;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ready <= '0;
		end else begin
			if (start) begin
				ready <= '0;
			end
			if (capture) begin
				ready[read_data.tag] <= 1'b1;
			end
		end
	end

	////////////////////
	// Edge shift out
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy <= 1'b0;
			slot <= '0;
			left <= '0;
			edge_valid <= 1'b0;
			line_done <= 1'b0;
		end else begin
			edge_valid <= 1'b0;
			line_done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				slot <= line_cmd.first_slot;
				left <= line_cmd.edge_count;
			end else if (busy) begin
				if (left != '0) begin
					edge_valid <= 1'b1;
					slot <= slot + 1'b1;
					left <= left - 1'b1;
				end else begin
					// Last edge went out last cycle
					busy <= 1'b0;
					line_done <= 1'b1;
				end
			end
		end
	end

	// Slot k sits at bits 32k up
	always_ff @(posedge clock) begin
		if (busy && (left != '0)) begin
			for (int i = 0; i < 3; i++) begin
				words[i] <= lines[i][slot * `EDGE_BITS +: `EDGE_BITS];
			end
		end
	end

	assign raw_edge.valid = edge_valid;
	assign raw_edge.id = '0;
	assign raw_edge.src = words[ARR_SRC];
	assign raw_edge.dest = words[ARR_DEST];
	assign raw_edge.weight = words[ARR_WEIGHT];

endmodule

// File: edge_job_queue.sv
`include "edge_defines.svh"

module edge_job_queue #(
	parameter int EDGE_QUEUE_DEPTH = `EDGE_QUEUE_DEPTH
) (
	input  logic             clock,
	input  logic             rstn,
	input  graph_pkg::edge_t raw_edge,
	input  logic             vertex_start,
	input  logic             edge_request,
	output graph_pkg::edge_t edge_out,
	output logic             queue_room
);
	import graph_pkg::*;

	localparam int COUNT_BITS = $clog2(EDGE_QUEUE_DEPTH + 1);

	edge_t                 edge_q;
	edge_t                 head;
	logic [`EDGE_BITS-1:0] id_count;
	logic                  empty;
	logic [COUNT_BITS-1:0] count;

	// Memory words arrive big endian
	function automatic logic [`EDGE_BITS-1:0] swap_bytes(input logic [`EDGE_BITS-1:0] word);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_q <= '0;
			id_count <= '0;
		end else begin
			edge_q.valid <= raw_edge.valid;
			if (raw_edge.valid) begin
				edge_q.id <= id_count;
				edge_q.src <= swap_bytes(raw_edge.src);
				edge_q.dest <= swap_bytes(raw_edge.dest);
				edge_q.weight <= swap_bytes(raw_edge.weight);
			end
			// Ids count from zero within each vertex
			if (vertex_start) begin
				id_count <= '0;
			end else if (raw_edge.valid) begin
				id_count <= id_count + 1'b1;
			end
		end
	end

	sync_fifo #(
		.WIDTH($bits(edge_t)),
		.DEPTH(EDGE_QUEUE_DEPTH)
	) edge_fifo_i (
		.clock(clock),
		.rstn(rstn),
		.push(edge_q.valid),
		.data_in(edge_q),
		.pop(edge_request),
		.data_out(head),
		.empty(empty),
		.count(count)
	);

	always_comb begin
		edge_out = head;
		edge_out.valid = !empty;
	end

	// The edge in the swap stage already owns a slot
	assign queue_room = (EDGE_QUEUE_DEPTH - int'(count) - int'(edge_q.valid)) >= `LINE_EDGES;

endmodule

// File: edge_job_control.sv
module edge_job_control (
	input  logic                   clock,
	input  logic                   rstn,
	input  graph_pkg::array_base_t base,
	input  logic                   cache_mode,
	input  graph_pkg::vertex_job_t vertex_in,
	output logic                   vertex_ready,
	output mem_pkg::read_cmd_t     read_cmd,
	input  mem_pkg::read_data_t    read_data,
	output graph_pkg::edge_t       edge_out,
	input  logic                   edge_request
);
	import graph_pkg::*;
	import mem_pkg::*;

	read_cmd_t line_cmd;
	edge_t     raw_edge;
	logic      vertex_start;
	logic      line_done;
	logic      queue_room;

	// Decode, issues line reads per vertex
	edge_read_request read_request_i (
		.clock(clock),
		.rstn(rstn),
		.base(base),
		.cache_mode(cache_mode),
		.vertex_in(vertex_in),
		.vertex_ready(vertex_ready),
		.queue_room(queue_room),
		.line_done(line_done),
		.read_cmd(read_cmd),
		.line_cmd(line_cmd),
		.vertex_start(vertex_start)
	);

	// Execute, gathers the three lines and walks the slots
	edge_line_unpack line_unpack_i (
		.clock(clock),
		.rstn(rstn),
		.read_data(read_data),
		.line_cmd(line_cmd),
		.raw_edge(raw_edge),
		.line_done(line_done)
	);

	// Result, swaps, numbers and queues edges
	edge_job_queue job_queue_i (
		.clock(clock),
		.rstn(rstn),
		.raw_edge(raw_edge),
		.vertex_start(vertex_start),
		.edge_request(edge_request),
		.edge_out(edge_out),
		.queue_room(queue_room)
	);

endmodule

// File: edge_job_assert.sv
module edge_job_assert (
	input logic               clock,
	input logic               rstn,
	input logic               vertex_ready,
	input mem_pkg::read_cmd_t read_cmd
);
	import mem_pkg::*;

	// Failed assertions, read back by the testbench
	int failures = 0;

	// Commands only while a vertex is in flight
	no_cmd_when_ready: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd.valid |-> !vertex_ready)
	else begin
		failures++;
		$error("read_cmd.valid high while vertex_ready is high");
	end

	// SRC, DEST, WEIGHT back to back
	cmd_order: assert property (@(posedge clock) disable iff (!rstn)
		(read_cmd.valid && read_cmd.tag == ARR_SRC) |=>
		(read_cmd.valid && read_cmd.tag == ARR_DEST) ##1
		(read_cmd.valid && read_cmd.tag == ARR_WEIGHT))
	else begin
		failures++;
		$error("read commands not in SRC, DEST, WEIGHT order");
	end

	nonzero_count: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd.valid |-> (read_cmd.edge_count != '0))
	else begin
		failures++;
		$error("read command with zero edge_count");
	end

endmodule

// File: tb_edge_job_control.sv
`include "edge_defines.svh"

module tb_edge_job_control;
	import graph_pkg::*;
	import mem_pkg::*;

	localparam int MEM_WORDS = 512;
	localparam int TOTAL_EDGES = 48 + 20 + 35 + 21 + 100 + 18;
	localparam int CYCLE_LIMIT = 200 * TOTAL_EDGES + 2000;

	logic        clock;
	logic        rstn;
	array_base_t base;
	logic        cache_mode;
	vertex_job_t vertex_in;
	logic        vertex_ready;
	read_cmd_t   read_cmd;
	read_data_t  read_data;
	edge_t       edge_out;
	logic        edge_request;

	logic [31:0] lfsr = 32'h3ac7_39d4;
	logic [31:0] mem_words [3][MEM_WORDS];
	read_data_t  staged[$];
	read_data_t  resp_q[$];
	int          gap_q[$];
	int          line_counts[$];
	int          line_slots[$];
	vertex_job_t cur_vertex;
	logic [63:0] exp_offset;
	int          exp_remaining;
	int          cmd_phase;
	int          cmd_count;
	int          popped;
	int          pop_period = 1;
	int          pop_phase;
	int          errors;
	int          tests;
	int          failed_tests;
	int          test_errors;
	int          cycles;

	edge_job_control dut_i (
		.clock(clock),
		.rstn(rstn),
		.base(base),
		.cache_mode(cache_mode),
		.vertex_in(vertex_in),
		.vertex_ready(vertex_ready),
		.read_cmd(read_cmd),
		.read_data(read_data),
		.edge_out(edge_out),
		.edge_request(edge_request)
	);

	bind edge_read_request edge_job_assert assert_i (
		.clock(clock),
		.rstn(rstn),
		.vertex_ready(vertex_ready),
		.read_cmd(read_cmd)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////
	// Helpers
	////////////////////

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return bits;
	endfunction

	function automatic logic [31:0] reverse_bytes(input logic [31:0] word);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

	function automatic logic [63:0] base_of(input array_tag_e tag);
		case (tag)
			ARR_SRC:  return base.src_base;
			ARR_DEST: return base.dest_base;
			default:  return base.weight_base;
		endcase
	endfunction

	// Memory holds each word byte reversed with slot k at line address plus 4k
	function automatic read_data_t build_line(input read_cmd_t cmd);
		read_data_t rsp;
		int         first_word;
		rsp = '0;
		rsp.valid = 1'b1;
		rsp.tag = cmd.tag;
		rsp.edge_count = cmd.edge_count;
		rsp.first_slot = cmd.first_slot;
		first_word = int'((cmd.address - base_of(cmd.tag)) >> 2);
		for (int k = 0; k < `LINE_EDGES; k++) begin
			rsp.line[k*32 +: 32] = reverse_bytes(mem_words[int'(cmd.tag)][first_word + k]);
		end
		return rsp;
	endfunction

	// Edge k of a vertex as the consumer should see it
	function automatic edge_t expected_edge(input vertex_job_t vertex, input int k);
		edge_t exp;
		int    idx;
		idx = int'(vertex.edge_idx) + k;
		exp.valid = 1'b1;
		exp.id = k;
		exp.src = mem_words[ARR_SRC][idx];
		exp.dest = mem_words[ARR_DEST][idx];
		exp.weight = mem_words[ARR_WEIGHT][idx];
		return exp;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Error at time %0t: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors > test_errors) begin
			failed_tests++;
			$display("Test %0d %s: %0d errors", tests, name, errors - test_errors);
		end else begin
			$display("Test %0d %s: ok", tests, name);
		end
		test_errors = errors;
	endtask

	// Hand in one vertex and wait until all its edges are popped
	task automatic run_vertex(input int idx, input int degree, input logic mode);
		@(posedge clock);
		cache_mode <= mode;
		vertex_in <= '{valid: 1'b1, id: 32'(tests + 1), edge_idx: 32'(idx), degree: 32'(degree)};
		do @(posedge clock); while (!vertex_ready);
		vertex_in.valid <= 1'b0;
		cur_vertex = '{valid: 1'b1, id: 32'(tests + 1), edge_idx: 32'(idx), degree: 32'(degree)};
		exp_offset = 64'(idx) * 4;
		exp_remaining = degree;
		cmd_phase = 0;
		popped = 0;
		line_counts.delete();
		line_slots.delete();
		while ((popped < degree) || !vertex_ready) begin
			@(posedge clock);
		end
		@(posedge clock);
		check_value("edge_out.valid", 0, edge_out.valid);
	endtask

	////////////////////
	// Memory model
	////////////////////

	always @(posedge clock) begin
		int pick;
		if (rstn && read_cmd.valid) begin
			staged.push_back(build_line(read_cmd));
			// Release the three lines in random order once all are in
			if (read_cmd.tag == ARR_WEIGHT) begin
				while (staged.size() > 0) begin
					pick = int'(lfsr_bits(2)) % staged.size();
					resp_q.push_back(staged[pick]);
					gap_q.push_back(1 + int'(lfsr_bits(3)));
					staged.delete(pick);
				end
			end
		end
		read_data <= '0;
		if (resp_q.size() > 0) begin
			if (gap_q[0] > 1) begin
				gap_q[0]--;
			end else begin
				read_data <= resp_q.pop_front();
				void'(gap_q.pop_front());
			end
		end
	end

	////////////////////
	// Checkers
	////////////////////

	always @(posedge clock) begin
		logic [63:0]  rem;
		logic [63:0]  aligned;
		int           count;
		array_tag_e   exp_tag;
		read_opcode_e exp_op;
		if (rstn && read_cmd.valid) begin
			cmd_count++;
			if (exp_remaining == 0) begin
				errors++;
				$display("Read command at time %0t with no edges left to fetch", $time);
			end else begin
				rem = exp_offset % `LINE_BYTES;
				aligned = exp_offset - rem;
				count = `LINE_EDGES - int'(rem / 4);
				if (exp_remaining < count) begin
					count = exp_remaining;
				end
				if (cache_mode) begin
					exp_op = READ_CL_S;
				end else begin
					exp_op = (count == exp_remaining) ? READ_PNA : READ_CL_NA;
				end
				exp_tag = array_tag_e'(cmd_phase);
				check_value("read_cmd.tag", exp_tag, read_cmd.tag);
				check_value("read_cmd.address", base_of(exp_tag) + aligned, read_cmd.address);
				check_value("read_cmd.edge_count", count, read_cmd.edge_count);
				check_value("read_cmd.first_slot", rem / 4, read_cmd.first_slot);
				check_value("read_cmd.opcode", exp_op, read_cmd.opcode);
				if (cmd_phase == 0) begin
					line_counts.push_back(count);
					line_slots.push_back(int'(rem / 4));
				end
				if (cmd_phase == 2) begin
					cmd_phase = 0;
					exp_offset = aligned + `LINE_BYTES;
					exp_remaining -= count;
				end else begin
					cmd_phase++;
				end
			end
		end
	end

	// Compare each popped edge
	always @(posedge clock) begin
		edge_t exp;
		if (rstn && edge_request && edge_out.valid) begin
			if (popped >= int'(cur_vertex.degree)) begin
				errors++;
				$display("Extra edge popped at time %0t beyond the vertex degree", $time);
			end else begin
				exp = expected_edge(cur_vertex, popped);
				check_value("edge_out.id", exp.id, edge_out.id);
				check_value("edge_out.src", exp.src, edge_out.src);
				check_value("edge_out.dest", exp.dest, edge_out.dest);
				check_value("edge_out.weight", exp.weight, edge_out.weight);
			end
			popped++;
		end
	end

	// Consumer pops once every pop_period cycles
	always @(posedge clock) begin
		if (!rstn) begin
			pop_phase = 0;
			edge_request <= 1'b0;
		end else begin
			edge_request <= (pop_phase == 0);
			pop_phase = (pop_phase + 1 >= pop_period) ? 0 : pop_phase + 1;
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Testbench failed");
		$finish;
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int cmds_before;
		int total;
		rstn = 1'b0;
		base = '{src_base: 64'h1000_0000, dest_base: 64'h2000_0000, weight_base: 64'h3000_0000};
		cache_mode = 1'b0;
		vertex_in = '0;
		read_data = '0;
		edge_request = 1'b0;
		for (int a = 0; a < 3; a++) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem_words[a][i] = lfsr_bits(32);
			end
		end
		repeat (8) @(posedge clock);
		rstn <= 1'b1;
		@(posedge clock);
		check_value("vertex_ready", 1, vertex_ready);
		check_value("read_cmd.valid", 0, read_cmd.valid);
		check_value("edge_out.valid", 0, edge_out.valid);
		check_value("line_done", 0, dut_i.line_done);
		end_test("reset");

		run_vertex(0, 48, 1'b0);
		check_value("line count", 3, line_counts.size());
		end_test("aligned vertex");

		run_vertex(5, 20, 1'b0);
		check_value("line count", 2, line_counts.size());
		if (line_counts.size() == 2) begin
			check_value("first line edge_count", 11, line_counts[0]);
			check_value("first line first_slot", 5, line_slots[0]);
			check_value("second line edge_count", 9, line_counts[1]);
		end
		end_test("misaligned start and short tail");

		// Opcode choice is checked on every command
		run_vertex(70, 35, 1'b1);
		run_vertex(110, 21, 1'b0);
		end_test("opcodes");

		pop_period = 6;
		run_vertex(130, 100, 1'b0);
		pop_period = 1;
		end_test("back-pressure");

		cmds_before = cmd_count;
		run_vertex(9, 0, 1'b0);
		// Sampled in the cycle right after the accept
		check_value("vertex_ready", 1, vertex_ready);
		repeat (10) @(posedge clock);
		check_value("read_cmd count", 0, cmd_count - cmds_before);
		run_vertex(250, 18, 1'b0);
		end_test("zero degree and id restart");

		total = errors + dut_i.read_request_i.assert_i.failures;
		$display("Tests: %0d run, %0d failed, %0d errors, %0d assertion failures",
			tests, failed_tests, errors, dut_i.read_request_i.assert_i.failures);
		if (total == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+.
graph_pkg.sv
mem_pkg.sv
sync_fifo.sv
edge_read_request.sv
edge_line_unpack.sv
edge_job_queue.sv
edge_job_control.sv
edge_job_assert.sv
tb_edge_job_control.sv
